// File: sifhConsts.svh
`ifndef SIFH_CONSTS_SVH
`define SIFH_CONSTS_SVH

`define Np 12                // one TDC event
`define PIX_BITS 2           // pixel index
`define TOF_BITS 10          // time of flight
`define Nb 4                 // bin index from the top bits of tof

`define BIN_NUM_PER_HIS 16
`define PIXEL_NUM_PER_RAM 4
`define RAM_ADDR 6           // {pixel, bin}

`define peakMax 8            // count width that saturates at all ones

`define DRAIN_CYCLES 3       // builder pipeline flush after frame end

`endif

// File: sifhPkg.sv
`include "sifhConsts.svh"

package sifhPkg;

    // photon event from the TDC
    typedef struct packed {
        logic [`PIX_BITS-1:0] pixel;
        logic [`TOF_BITS-1:0] tof;
    } tdcEvent_t;

    typedef struct packed {
        logic                 en;
        logic [`RAM_ADDR-1:0] addr;
        logic [`peakMax-1:0]  count;
    } ramWrite_t;

    typedef struct packed {
        logic                 en;
        logic [`RAM_ADDR-1:0] addr;
    } ramRead_t;

    // one result per pixel
    typedef struct packed {
        logic [`PIX_BITS-1:0] pixel;
        logic [`Nb-1:0]       bin;
        logic [`peakMax-1:0]  count;
        logic                 lastPixel;  // set on the final pixel of a scan
    } peakResult_t;

endpackage

// File: histRam.sv
`timescale 1ns/100ps
`include "sifhConsts.svh"

module histRam
    import sifhPkg::*;
(
    input  logic                clk,
    input  ramWrite_t           wr,
    input  ramRead_t            rd,
    output logic [`peakMax-1:0] rdCount
);

    localparam int DEPTH = `BIN_NUM_PER_HIS * `PIXEL_NUM_PER_RAM;

    logic [`peakMax-1:0] mem [0:DEPTH-1];

    // write port
    always_ff @(posedge clk) begin
        if (wr.en) begin
            mem[wr.addr] <= wr.count;
        end
    end

    // read port returns old data on a same-address collision
    always_ff @(posedge clk) begin
        if (rd.en) begin
            rdCount <= mem[rd.addr];
        end
    end

endmodule

// File: histBuilder.sv
`timescale 1ns/100ps
`include "sifhConsts.svh"

module histBuilder
    import sifhPkg::*;
(
    input  logic                clk,
    input  logic                res,
    input  logic                eventValid,
    input  tdcEvent_t           tdcEvent,
    output ramRead_t            rd,
    input  logic [`peakMax-1:0] rdCount,
    output ramWrite_t           wr
);

    localparam logic [`peakMax-1:0] COUNT_MAX = '1;

    logic [`RAM_ADDR-1:0] binAddr;

    logic                 s1Valid;   // read data arrives this cycle
    logic [`RAM_ADDR-1:0] s1Addr;
    logic                 s2Valid;   // write stage
    logic [`RAM_ADDR-1:0] s2Addr;
    logic [`peakMax-1:0]  s2Count;
    logic                 lwValid;   // write committed last cycle
    logic [`RAM_ADDR-1:0] lwAddr;
    logic [`peakMax-1:0]  lwCount;

    logic [`peakMax-1:0]  curCount;
    logic [`peakMax-1:0]  nextCount;

    assign binAddr = {tdcEvent.pixel, tdcEvent.tof[`TOF_BITS-1 -: `Nb]};

    assign rd = '{en: eventValid, addr: binAddr};

    // newest copy of the bin wins
    always_comb begin
        if (s2Valid && s2Addr == s1Addr) begin
            curCount = s2Count;        // not yet written
        end else if (lwValid && lwAddr == s1Addr) begin
            curCount = lwCount;        // written while the RAM was read
        end else begin
            curCount = rdCount;
        end
        nextCount = (curCount == COUNT_MAX) ? curCount : curCount + 1'b1;
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            lwValid <= 1'b0;
        end else begin
            s1Valid <= eventValid;
            s2Valid <= s1Valid;
            lwValid <= s2Valid;
        end
    end

    always_ff @(posedge clk) begin
        s1Addr  <= binAddr;
        s2Addr  <= s1Addr;
        s2Count <= nextCount;
        lwAddr  <= s2Addr;
        lwCount <= s2Count;
    end

    assign wr = '{en: s2Valid, addr: s2Addr, count: s2Count};

    // a written bin always holds at least the event behind the write
    aWriteNotEmpty: assert property (
        @(posedge clk) disable iff (!res)
        wr.en |-> wr.count != '0
    );

    // back-to-back writes to one bin keep climbing until saturation
    aCountClimbs: assert property (
        @(posedge clk) disable iff (!res)
        wr.en && $past(wr.en) && wr.addr == $past(wr.addr)
        |-> wr.count > $past(wr.count) || wr.count == COUNT_MAX
    );

endmodule

// File: peakFinder.sv
`timescale 1ns/100ps
`include "sifhConsts.svh"

module peakFinder
    import sifhPkg::*;
(
    input  logic                clk,
    input  logic                res,
    input  logic                scanStart,
    output ramRead_t            rd,
    input  logic [`peakMax-1:0] rdCount,
    output logic                peakValid,
    output peakResult_t         peakResult
);

    localparam int LAST_STEP = `BIN_NUM_PER_HIS + 1;  // 16 reads, compare, emit
    localparam logic [`PIX_BITS-1:0] LAST_PIX = `PIX_BITS'(`PIXEL_NUM_PER_RAM - 1);

    logic                 active;
    logic [`PIX_BITS-1:0] pix;
    logic [`Nb:0]         step;      // msb set once all bins are read
    logic                 lastStep;
    logic                 dValid;    // rdCount holds a bin this cycle
    logic [`Nb-1:0]       dBin;
    logic [`Nb-1:0]       maxBin;
    logic [`peakMax-1:0]  maxCount;

    assign lastStep = active && step == LAST_STEP[`Nb:0];

    assign rd = '{en: active && !step[`Nb], addr: {pix, step[`Nb-1:0]}};

    assign peakValid  = lastStep;
    assign peakResult = '{pixel: pix, bin: maxBin, count: maxCount,
                          lastPixel: pix == LAST_PIX};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            active <= 1'b0;
            pix    <= '0;
            step   <= '0;
            dValid <= 1'b0;
        end else begin
            dValid <= rd.en;
            if (scanStart) begin
                active <= 1'b1;
                pix    <= '0;
                step   <= '0;
            end else if (lastStep) begin
                step <= '0;
                pix  <= pix + 1'b1;
                if (pix == LAST_PIX) begin
                    active <= 1'b0;
                end
            end else if (active) begin
                step <= step + 1'b1;
            end
        end
    end

    // bin 0 restarts the maximum and a strict compare keeps the lowest bin on ties
    always_ff @(posedge clk) begin
        dBin <= step[`Nb-1:0];
        if (dValid && (dBin == '0 || rdCount > maxCount)) begin
            maxBin   <= dBin;
            maxCount <= rdCount;
        end
    end

    // results only inside a scan and right after the last bin of the pixel came back
    aPeakInScan: assert property (
        @(posedge clk) disable iff (!res)
        peakValid |-> active && $past(rd.en, 2) && !$past(rd.en)
    );

endmodule

// File: sifhTop.sv
`timescale 1ns/100ps
`include "sifhConsts.svh"

module sifhTop
    import sifhPkg::*;
(
    input  logic        clk,
    input  logic        res,
    input  logic        eventValid,
    input  tdcEvent_t   tdcEvent,
    input  logic        frameEnd,
    output logic        acquireEn,
    output logic        peakValid,
    output peakResult_t peakResult
);

    typedef enum logic [2:0] {
        CLEAR,
        ACQUIRE,
        DRAIN,
        SCAN,
        WAITSCAN
    } state_t;

    localparam logic [`RAM_ADDR-1:0] LAST_ADDR  = '1;
    localparam logic [1:0]           DRAIN_LAST = 2'(`DRAIN_CYCLES - 1);

    state_t               state;
    logic [`RAM_ADDR-1:0] clrAddr;
    logic [1:0]           drainCnt;
    logic                 evAccept;
    logic                 scanStart;

    ramRead_t             hbRd;
    ramRead_t             pfRd;
    ramRead_t             ramRd;
    ramWrite_t            hbWr;
    ramWrite_t            clrWr;
    ramWrite_t            ramWr;
    logic [`peakMax-1:0]  rdCount;

    assign acquireEn = state == ACQUIRE;
    assign evAccept  = acquireEn && eventValid;  // TDC events outside a frame are dropped
    assign scanStart = state == SCAN;
    assign clrWr     = '{en: state == CLEAR, addr: clrAddr, count: '0};

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state    <= CLEAR;
            clrAddr  <= '0;
            drainCnt <= '0;
        end else begin
            case (state)
                CLEAR: begin
                    clrAddr <= clrAddr + 1'b1;  // wraps back to 0 for the next clear
                    if (clrAddr == LAST_ADDR) begin
                        state <= ACQUIRE;
                    end
                end
                ACQUIRE: begin
                    if (frameEnd) begin
                        state    <= DRAIN;
                        drainCnt <= '0;
                    end
                end
                DRAIN: begin
                    drainCnt <= drainCnt + 1'b1;
                    if (drainCnt == DRAIN_LAST) begin
                        state <= SCAN;
                    end
                end
                SCAN: state <= WAITSCAN;        // one-cycle scanStart
                WAITSCAN: begin
                    if (peakValid && peakResult.lastPixel) begin
                        state <= CLEAR;
                    end
                end
                default: state <= CLEAR;
            endcase
        end
    end

    // RAM port ownership
    always_comb begin
        ramWr = hbWr;
        ramRd = hbRd;
        case (state)
            CLEAR:          ramWr = clrWr;
            SCAN, WAITSCAN: ramRd = pfRd;
            default: ;
        endcase
    end

    histRam uRam (
        .clk     (clk),
        .wr      (ramWr),
        .rd      (ramRd),
        .rdCount (rdCount)
    );

    histBuilder uBuilder (
        .clk        (clk),
        .res        (res),
        .eventValid (evAccept),
        .tdcEvent   (tdcEvent),
        .rd         (hbRd),
        .rdCount    (rdCount),
        .wr         (hbWr)
    );

    peakFinder uPeak (
        .clk        (clk),
        .res        (res),
        .scanStart  (scanStart),
        .rd         (pfRd),
        .rdCount    (rdCount),
        .peakValid  (peakValid),
        .peakResult (peakResult)
    );

    // builder and peak finder share one read port
    aOneReader: assert property (
        @(posedge clk) disable iff (!res)
        !(hbRd.en && pfRd.en)
    );

endmodule

// File: sifhTb.sv
`timescale 1ns/100ps
`include "sifhConsts.svh"

module sifhTb
    import sifhPkg::*;
();

    localparam int PIX_NUM     = `PIXEL_NUM_PER_RAM;
    localparam int BIN_NUM     = `BIN_NUM_PER_HIS;
    localparam int COUNT_LIMIT = (1 << `peakMax) - 1;
    localparam int TIMEOUT     = 300;  // cycles allowed per wait

    logic        clk;
    logic        res;
    logic        eventValid;
    tdcEvent_t   tdcEvent;
    logic        frameEnd;
    logic        acquireEn;
    logic        peakValid;
    peakResult_t peakResult;

    integer      seed;
    int          tally [0:PIX_NUM-1][0:BIN_NUM-1];  // accepted events of this frame
    peakResult_t expPeak [0:PIX_NUM-1];
    peakResult_t want;
    int          gotResults;
    int          checks;
    int          mismatches;
    int          otherErrs;
    bit          scanOpen;  // results may arrive
    bit          timedOut;

    sifhTop uut (
        .clk        (clk),
        .res        (res),
        .eventValid (eventValid),
        .tdcEvent   (tdcEvent),
        .frameEnd   (frameEnd),
        .acquireEn  (acquireEn),
        .peakValid  (peakValid),
        .peakResult (peakResult)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // expected peak of one pixel with saturated counts and the lowest bin winning a tie
    function automatic peakResult_t refPeak(input int pix);
        peakResult_t r;
        int          c;
        int          best;
        best  = (tally[pix][0] > COUNT_LIMIT) ? COUNT_LIMIT : tally[pix][0];
        r.pixel = pix[`PIX_BITS-1:0];
        r.bin   = '0;
        for (int b = 1; b < BIN_NUM; b++) begin
            c = (tally[pix][b] > COUNT_LIMIT) ? COUNT_LIMIT : tally[pix][b];
            if (c > best) begin
                best  = c;
                r.bin = b[`Nb-1:0];
            end
        end
        r.count     = best[`peakMax-1:0];
        r.lastPixel = (pix == PIX_NUM - 1);
        return r;
    endfunction

    // results come in ascending pixel order
    always @(negedge clk) begin
        if (res && peakValid) begin
            if (!scanOpen || gotResults >= PIX_NUM) begin
                otherErrs++;
                $display("peakValid arrived with no scan pending at %0t", $time);
            end else begin
                want = expPeak[gotResults];
                checks++;
                if (peakResult.pixel !== want.pixel) begin
                    mismatches++;
                    $display("Mismatch peakResult.pixel: got %h expected %h",
                             peakResult.pixel, want.pixel);
                end
                if (peakResult.bin !== want.bin) begin
                    mismatches++;
                    $display("Mismatch peakResult.bin (pixel %0d): got %h expected %h",
                             want.pixel, peakResult.bin, want.bin);
                end
                if (peakResult.count !== want.count) begin
                    mismatches++;
                    $display("Mismatch peakResult.count (pixel %0d): got %h expected %h",
                             want.pixel, peakResult.count, want.count);
                end
                if (peakResult.lastPixel !== want.lastPixel) begin
                    mismatches++;
                    $display("Mismatch peakResult.lastPixel (pixel %0d): got %h expected %h",
                             want.pixel, peakResult.lastPixel, want.lastPixel);
                end
                gotResults++;
            end
        end
    end

    task automatic idleInputs();
        eventValid = 1'b0;
        frameEnd   = 1'b0;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) begin
            @(negedge clk);
            idleInputs();
        end
    endtask

    // junk on every input while acquireEn is low
    task automatic driveNoise();
        logic [31:0] r;
        r          = $random(seed);
        eventValid = r[0];
        frameEnd   = r[1];
        tdcEvent   = r[13:2];
    endtask

    task automatic sendEvent(input logic [`PIX_BITS-1:0] pix, input logic [`TOF_BITS-1:0] tof);
        @(negedge clk);
        eventValid = 1'b1;
        frameEnd   = 1'b0;
        tdcEvent   = '{pixel: pix, tof: tof};
        if (!acquireEn) begin
            otherErrs++;
            $display("acquireEn dropped in the middle of a frame at %0t", $time);
        end else begin
            tally[pix][tof[`TOF_BITS-1 -: `Nb]]++;
        end
    endtask

    task automatic waitAcquire(input bit noisy);
        int n;
        n = 0;
        @(negedge clk);
        while (!acquireEn && n < TIMEOUT) begin
            if (noisy) driveNoise();
            else idleInputs();
            @(negedge clk);
            n++;
        end
        idleInputs();
        if (!acquireEn) begin
            otherErrs++;
            timedOut = 1'b1;
            $display("timeout waiting for acquireEn at %0t", $time);
        end
        for (int p = 0; p < PIX_NUM; p++) begin
            for (int b = 0; b < BIN_NUM; b++) tally[p][b] = 0;
        end
    endtask

    // frameEnd with an optional last event in the same cycle
    task automatic endFrame(input bit withEvent);
        logic [31:0] r;
        @(negedge clk);
        frameEnd   = 1'b1;
        eventValid = 1'b0;
        if (withEvent) begin
            r          = $random(seed);
            eventValid = 1'b1;
            tdcEvent   = '{pixel: r[1:0], tof: r[11:2]};
            tally[r[1:0]][r[11:8]]++;
        end
        for (int p = 0; p < PIX_NUM; p++) expPeak[p] = refPeak(p);
        gotResults = 0;
        scanOpen   = 1'b1;
    endtask

    // result count is read on the rising edge, after the checker has settled it
    task automatic waitResults(input bit noisy);
        int n;
        n = 0;
        while (gotResults < PIX_NUM && n < TIMEOUT) begin
            @(negedge clk);
            if (noisy && !acquireEn) driveNoise();
            else idleInputs();
            n++;
            @(posedge clk);
        end
        if (gotResults < PIX_NUM) begin
            otherErrs++;
            timedOut = 1'b1;
            $display("timeout with only %0d of %0d peak results received", gotResults, PIX_NUM);
        end
        scanOpen = 1'b0;
    endtask

    task automatic randomFrame(input int num, input bit noisy);
        logic [31:0] r;
        waitAcquire(noisy);
        if (!timedOut) begin
            for (int i = 0; i < num; i++) begin
                r = $random(seed);
                sendEvent(r[1:0], r[11:2]);
                if (r[14:12] == 3'd0) idleCycles(int'(r[17:16]) + 1);  // random gap
            end
            endFrame(1'b1);
            waitResults(noisy);
        end
    endtask

    // same-bin and alternating-bin hazards
    task automatic forwardFrame();
        waitAcquire(1'b0);
        if (!timedOut) begin
            repeat (7) sendEvent(2'd1, {4'd5, 6'd17});
            repeat (10) begin
                sendEvent(2'd2, {4'd3, 6'd0});
                sendEvent(2'd2, {4'd9, 6'd63});
            end
            sendEvent(2'd0, {4'd12, 6'd1});
            idleCycles(1);
            sendEvent(2'd0, {4'd12, 6'd2});
            sendEvent(2'd0, {4'd12, 6'd3});
            sendEvent(2'd3, {4'd7, 6'd0});
            sendEvent(2'd3, {4'd7, 6'd0});
            sendEvent(2'd3, {4'd2, 6'd0});
            sendEvent(2'd3, {4'd7, 6'd0});
            repeat (3) sendEvent(2'd3, {4'd2, 6'd5});
            endFrame(1'b0);
            waitResults(1'b0);
        end
    endtask

    task automatic saturateFrame();
        logic [31:0] r;
        waitAcquire(1'b0);
        if (!timedOut) begin
            repeat (300) begin
                r = $random(seed);
                sendEvent(2'd3, {4'd15, r[5:0]});
            end
            sendEvent(2'd0, {4'd1, 6'd0});
            endFrame(1'b0);
            waitResults(1'b1);
        end
    endtask

    initial begin
        seed       = 32'hf849_fd4b;
        res        = 1'b0;
        eventValid = 1'b0;
        frameEnd   = 1'b0;
        tdcEvent   = '0;
        gotResults = 0;
        checks     = 0;
        mismatches = 0;
        otherErrs  = 0;
        scanOpen   = 1'b0;
        timedOut   = 1'b0;
        repeat (3) @(negedge clk);
        if (acquireEn !== 1'b0 || peakValid !== 1'b0) begin
            otherErrs++;
            $display("acquireEn or peakValid not low during reset");
        end
        res = 1'b1;
        randomFrame(150, 1'b0);
        forwardFrame();
        saturateFrame();
        randomFrame(100, 1'b1);  // follows a frame gap full of junk inputs
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, otherErrs);
        if (mismatches == 0 && otherErrs == 0 && checks > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+.
sifhPkg.sv
histRam.sv
histBuilder.sv
peakFinder.sv
sifhTop.sv
sifhTb.sv

// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f files.f --top-module sifhTb -o sifhSim
	./obj_dir/sifhSim | tee /dev/stderr | grep -qx "TEST PASSED"

clean:
	rm -rf obj_dir
